// ==== Bender.yml ====
package:
  name: ssb_receiver

sources:
  - rtl/ssb_pkg.sv
  - rtl/ssb_stream_if.sv
  - rtl/pss_detector.sv
  - rtl/frame_sync.sv
  - rtl/fft_demod.sv
  - rtl/bwp_extractor.sv
  - rtl/ssb_receiver.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_ssb_receiver.sv

// ==== all.f ====
+incdir+verif
rtl/ssb_pkg.sv
rtl/ssb_stream_if.sv
rtl/pss_detector.sv
rtl/frame_sync.sv
rtl/fft_demod.sv
rtl/bwp_extractor.sv
rtl/ssb_receiver.sv
verif/tb_ssb_receiver.sv

// ==== rtl/bwp_extractor.sv ====
`timescale 1ns/1ps

module bwp_extractor import ssb_pkg::*; #(
    parameter int SC_START = 4,
    parameter int SC_NUM   = 8
) (
    input  logic          clk_i,
    input  logic          rst_n_i,
    ssb_stream_if.sink    s,
    output sample_t       m_tdata_o,
    output bin_user_t     m_tuser_o,
    output logic          m_tvalid_o,
    output logic          m_tlast_o,
    output logic          pbch_valid_o,
    output logic          sss_valid_o
);

    logic in_band_w;
    logic band_end_w;
    logic is_pbch_w;

    assign in_band_w  = s.tvalid && (int'(s.tuser.bin) >= SC_START) &&
                        (int'(s.tuser.bin) < SC_START + SC_NUM);
    assign band_end_w = (int'(s.tuser.bin) == SC_START + SC_NUM - 1);
    assign is_pbch_w  = (s.tuser.sym == 2'd1) || (s.tuser.sym == 2'd3);   // SSS sits between

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            m_tvalid_o   <= 1'b0;
            m_tlast_o    <= 1'b0;
            pbch_valid_o <= 1'b0;
            sss_valid_o  <= 1'b0;
        end else begin
            m_tvalid_o   <= in_band_w;
            m_tlast_o    <= in_band_w && band_end_w;
            pbch_valid_o <= in_band_w && is_pbch_w;
            sss_valid_o  <= in_band_w && (s.tuser.sym == 2'd2);
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_band_w) begin
            m_tdata_o <= s.tdata;
            m_tuser_o <= s.tuser;
        end
    end

endmodule

// ==== rtl/fft_demod.sv ====
`timescale 1ns/1ps

module fft_demod import ssb_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_n_i,
    ssb_stream_if.sink    s,
    ssb_stream_if.source  m
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CALC,
        ST_OUT
    } state_t;

    state_t             state_q;
    sample_t            mem_q [2][FFT_LEN];
    sym_idx_t           sym_tag_q [2];
    logic [1:0]         bank_full_q;
    logic               wr_bank_q;
    logic               proc_bank_q;
    logic [1:0]         stage_q;
    logic [2:0]         bfly_q;
    logic [3:0]         out_cnt_q;

    logic [3:0]         wr_addr_w;
    logic [3:0]         half_w;
    logic [2:0]         k_w;
    logic [3:0]         top_idx_w;
    logic [3:0]         bot_idx_w;
    logic [2:0]         tw_idx_w;
    sample_t            top_w;
    sample_t            bot_w;
    sample_t            top_new_w;
    sample_t            bot_new_w;
    logic signed [15:0] tw_re_w;
    logic signed [15:0] tw_im_w;
    logic signed [31:0] prod_re_w;
    logic signed [31:0] prod_im_w;
    logic signed [31:0] t_re_w;
    logic signed [31:0] t_im_w;

    // input lands bit reversed so the in-place DIT ends in natural order
    assign wr_addr_w = {s.tuser.bin[0], s.tuser.bin[1], s.tuser.bin[2], s.tuser.bin[3]};

    // ========================================
    // butterfly addressing and arithmetic
    // ========================================
    always_comb begin
        half_w    = 4'd1 << stage_q;
        k_w       = bfly_q & 3'(half_w - 4'd1);
        top_idx_w = (({1'b0, bfly_q} >> stage_q) << (stage_q + 3'd1)) | {1'b0, k_w};
        bot_idx_w = top_idx_w | half_w;
        tw_idx_w  = k_w << (3'd3 - stage_q);
        tw_re_w   = TWIDDLE_RE[tw_idx_w];
        tw_im_w   = TWIDDLE_IM[tw_idx_w];
        top_w     = mem_q[proc_bank_q][top_idx_w];
        bot_w     = mem_q[proc_bank_q][bot_idx_w];

        prod_re_w = bot_w.re * tw_re_w - bot_w.im * tw_im_w;
        prod_im_w = bot_w.re * tw_im_w + bot_w.im * tw_re_w;
        t_re_w    = prod_re_w >>> 14;    // floor back to Q0
        t_im_w    = prod_im_w >>> 14;

        // halve every stage so 4 stages cannot overflow
        top_new_w.re = 16'((top_w.re + t_re_w) >>> 1);
        top_new_w.im = 16'((top_w.im + t_im_w) >>> 1);
        bot_new_w.re = 16'((top_w.re - t_re_w) >>> 1);
        bot_new_w.im = 16'((top_w.im - t_im_w) >>> 1);
    end

    // ========================================
    // bank control and sequencing
    // ========================================
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= ST_IDLE;
            bank_full_q <= '0;
            wr_bank_q   <= 1'b0;
            proc_bank_q <= 1'b0;
            stage_q     <= '0;
            bfly_q      <= '0;
            out_cnt_q   <= '0;
            m.tvalid    <= 1'b0;
            m.tlast     <= 1'b0;
        end else begin
            m.tvalid <= 1'b0;
            m.tlast  <= 1'b0;
            if (s.tvalid && s.tlast) begin
                bank_full_q[wr_bank_q] <= 1'b1;
                wr_bank_q              <= !wr_bank_q;
            end
            case (state_q)
                ST_IDLE: begin
                    if (bank_full_q[proc_bank_q]) begin
                        state_q <= ST_CALC;
                        stage_q <= '0;
                        bfly_q  <= '0;
                    end
                end
                ST_CALC: begin
                    bfly_q <= bfly_q + 3'd1;
                    if (bfly_q == 3'd7) begin
                        stage_q <= stage_q + 2'd1;
                        if (stage_q == 2'd3) begin
                            state_q   <= ST_OUT;
                            out_cnt_q <= '0;
                        end
                    end
                end
                ST_OUT: begin
                    m.tvalid  <= 1'b1;
                    m.tlast   <= (out_cnt_q == 4'd15);
                    out_cnt_q <= out_cnt_q + 4'd1;
                    if (out_cnt_q == 4'd15) begin
                        bank_full_q[proc_bank_q] <= 1'b0;
                        proc_bank_q              <= !proc_bank_q;
                        state_q                  <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (s.tvalid) begin
            mem_q[wr_bank_q][wr_addr_w] <= s.tdata;
        end
        if (s.tvalid && s.tlast) begin
            sym_tag_q[wr_bank_q] <= s.tuser.sym;
        end
        if (state_q == ST_CALC) begin
            mem_q[proc_bank_q][top_idx_w] <= top_new_w;
            mem_q[proc_bank_q][bot_idx_w] <= bot_new_w;
        end
        if (state_q == ST_OUT) begin
            m.tdata     <= mem_q[proc_bank_q][out_cnt_q];
            m.tuser.sym <= sym_tag_q[proc_bank_q];
            m.tuser.bin <= out_cnt_q;
        end
    end

    // the upstream rate must leave the write bank free until its transform has drained
    a_no_overrun: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) s.tvalid |-> !bank_full_q[wr_bank_q]
    );

endmodule

// ==== rtl/frame_sync.sv ====
`timescale 1ns/1ps

module frame_sync import ssb_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          peak_i,
    ssb_stream_if.sink    s,
    ssb_stream_if.source  m,
    output logic          search_en_o
);

    localparam int SYM_LEN = CP_LEN + FFT_LEN;

    logic       active_q;
    sym_idx_t   sym_q;
    logic [4:0] pos_q;      // sample position inside the current symbol
    logic       take_w;
    logic       in_body_w;
    logic       sym_end_w;
    logic [3:0] bin_w;

    assign take_w    = active_q && s.tvalid;
    assign in_body_w = (pos_q >= CP_LEN);
    assign sym_end_w = (pos_q == SYM_LEN - 1);
    assign bin_w     = 4'(pos_q - CP_LEN);

    // ========================================
    // symbol counting
    // ========================================
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            active_q <= 1'b0;
            sym_q    <= '0;
            pos_q    <= '0;
            m.tvalid <= 1'b0;
            m.tlast  <= 1'b0;
        end else begin
            m.tvalid <= 1'b0;
            m.tlast  <= 1'b0;
            if (peak_i) begin
                // the peak beat is the last sync sample, counting starts after it
                active_q <= 1'b1;
                sym_q    <= sym_idx_t'(1);
                pos_q    <= '0;
            end else if (take_w) begin
                m.tvalid <= in_body_w;      // prefix samples are dropped
                m.tlast  <= sym_end_w;
                if (sym_end_w) begin
                    pos_q <= '0;
                    sym_q <= sym_q + 2'd1;
                    if (sym_q == SYM_PER_SSB) begin
                        active_q <= 1'b0;
                    end
                end else begin
                    pos_q <= pos_q + 5'd1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_w) begin
            m.tdata     <= s.tdata;
            m.tuser.sym <= sym_q;
            m.tuser.bin <= bin_w;
        end
    end

    assign search_en_o = !active_q;   // no search while an SSB is being cut

endmodule

// ==== rtl/pss_detector.sv ====
`timescale 1ns/1ps

module pss_detector import ssb_pkg::*; #(
    parameter int unsigned THRESHOLD = 16000
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  sample_t             s_tdata_i,
    input  logic                s_tvalid_i,
    input  logic                search_en_i,
    ssb_stream_if.source        m,
    output logic                peak_o
);

    localparam int ACC_W = 22;

    sample_t                   shift_q [FFT_LEN];  // shift_q[0] is the newest sample
    logic                      valid_d1_q;
    logic signed [ACC_W-1:0]   acc_re_w;
    logic signed [ACC_W-1:0]   acc_im_w;
    logic        [ACC_W-1:0]   abs_re_w;
    logic        [ACC_W-1:0]   abs_im_w;
    logic        [ACC_W:0]     mag_w;

    // ========================================
    // sample window
    // ========================================
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < FFT_LEN; i++) begin
                shift_q[i] <= '0;
            end
            valid_d1_q <= 1'b0;
        end else begin
            valid_d1_q <= s_tvalid_i;
            if (s_tvalid_i) begin
                shift_q[0] <= s_tdata_i;
                for (int i = 1; i < FFT_LEN; i++) begin
                    shift_q[i] <= shift_q[i-1];
                end
            end
        end
    end

    // ========================================
    // correlation against the local sequence
    // ========================================
    always_comb begin
        acc_re_w = '0;
        acc_im_w = '0;
        for (int j = 0; j < FFT_LEN; j++) begin
            // newest sample pairs with the last sequence element
            if (PSS_SEQ[FFT_LEN-1-j]) begin
                acc_re_w = acc_re_w - shift_q[j].re;
                acc_im_w = acc_im_w - shift_q[j].im;
            end else begin
                acc_re_w = acc_re_w + shift_q[j].re;
                acc_im_w = acc_im_w + shift_q[j].im;
            end
        end
        abs_re_w = acc_re_w[ACC_W-1] ? -acc_re_w : acc_re_w;
        abs_im_w = acc_im_w[ACC_W-1] ? -acc_im_w : acc_im_w;
        mag_w    = {1'b0, abs_re_w} + {1'b0, abs_im_w};   // cheap |re|+|im| magnitude
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            peak_o   <= 1'b0;
            m.tvalid <= 1'b0;
        end else begin
            peak_o   <= valid_d1_q && search_en_i && (mag_w >= THRESHOLD);
            m.tvalid <= valid_d1_q;
        end
    end

    always_ff @(posedge clk_i) begin
        m.tdata <= shift_q[0];   // second stage of the 2 clock delay
    end

    assign m.tuser = '0;
    assign m.tlast = 1'b0;

    // search_en only falls after a peak has been taken by the framer
    a_peak_in_search: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) peak_o |-> search_en_i
    );

endmodule

// ==== rtl/ssb_pkg.sv ====
package ssb_pkg;

    // ========================================
    // stream payloads
    // ========================================
    typedef struct packed {
        logic signed [15:0] re;
        logic signed [15:0] im;
    } sample_t;

    localparam int FFT_LEN     = 16;   // also the sync sequence length
    localparam int CP_LEN      = 4;
    localparam int SYM_PER_SSB = 3;

    typedef logic [1:0] sym_idx_t;     // 1 to 3 after the sync symbol

    typedef struct packed {
        sym_idx_t   sym;
        logic [3:0] bin;
    } bin_user_t;

    // ========================================
    // constant tables
    // ========================================
    // bit i is sequence element i, a set bit means -1
    localparam logic [FFT_LEN-1:0] PSS_SEQ = 16'b0001_1010_1100_1110;

    // Q1.14 cos(2*pi*k/16)
    localparam logic signed [15:0] TWIDDLE_RE [0:7] = '{
        16'sd16384, 16'sd15137, 16'sd11585, 16'sd6270,
        16'sd0, -16'sd6270, -16'sd11585, -16'sd15137
    };

    // Q1.14 -sin(2*pi*k/16)
    localparam logic signed [15:0] TWIDDLE_IM [0:7] = '{
        16'sd0, -16'sd6270, -16'sd11585, -16'sd15137,
        -16'sd16384, -16'sd15137, -16'sd11585, -16'sd6270
    };

endpackage

// ==== rtl/ssb_receiver.sv ====
`timescale 1ns/1ps

module ssb_receiver import ssb_pkg::*; #(
    parameter int unsigned THRESHOLD = 16000,
    parameter int          SC_START  = 4,
    parameter int          SC_NUM    = 8
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  sample_t   s_tdata_i,
    input  logic      s_tvalid_i,
    output sample_t   m_tdata_o,
    output bin_user_t m_tuser_o,
    output logic      m_tvalid_o,
    output logic      m_tlast_o,
    output logic      pbch_valid_o,
    output logic      sss_valid_o
);

    logic peak;
    logic search_en;

    ssb_stream_if #(.payload_t(sample_t)) det_s ();
    ssb_stream_if #(.payload_t(sample_t)) sym_s ();
    ssb_stream_if #(.payload_t(sample_t)) bin_s ();

    // ========================================
    // receive chain
    // ========================================
    pss_detector #(.THRESHOLD(THRESHOLD)) u_pss_detector (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .s_tdata_i(s_tdata_i), .s_tvalid_i(s_tvalid_i),
        .search_en_i(search_en), .m(det_s.source), .peak_o(peak)
    );

    frame_sync u_frame_sync (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .peak_i(peak),
        .s(det_s.sink), .m(sym_s.source), .search_en_o(search_en)
    );

    fft_demod u_fft_demod (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .s(sym_s.sink), .m(bin_s.source)
    );

    bwp_extractor #(.SC_START(SC_START), .SC_NUM(SC_NUM)) u_bwp_extractor (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .s(bin_s.sink),
        .m_tdata_o(m_tdata_o), .m_tuser_o(m_tuser_o),
        .m_tvalid_o(m_tvalid_o), .m_tlast_o(m_tlast_o),
        .pbch_valid_o(pbch_valid_o), .sss_valid_o(sss_valid_o)
    );

endmodule

// ==== rtl/ssb_stream_if.sv ====
`timescale 1ns/1ps

interface ssb_stream_if import ssb_pkg::*; #(
    parameter type payload_t = sample_t
) ();

    payload_t  tdata;
    bin_user_t tuser;
    logic      tlast;
    logic      tvalid;   // one beat per high cycle, no back-pressure

    modport source (
        output tdata,
        output tuser,
        output tlast,
        output tvalid
    );

    modport sink (
        input tdata,
        input tuser,
        input tlast,
        input tvalid
    );

endinterface

// ==== verif/ssb_model.svh ====
`ifndef SSB_MODEL_SVH
`define SSB_MODEL_SVH

typedef struct packed {
    sample_t   data;
    bin_user_t user;
    logic      last;
    logic      pbch;
    logic      sss;
} beat_t;

beat_t   exp_q [$];
sample_t win_m [FFT_LEN] = '{default: '0};   // win_m[0] is the oldest sample
sample_t body_m [FFT_LEN];
logic    active_m = 1'b0;
int      sym_m = 0;
int      pos_m = 0;
int      peaks_m = 0;

// in-place radix-2 DIT on bit-reversed input, both outputs halved
task automatic transform_symbol(input int sym);
    int    a_re [FFT_LEN];
    int    a_im [FFT_LEN];
    int    top, bot, tw, p_re, p_im, t_re, t_im, rev;
    beat_t b;
    for (int n = 0; n < FFT_LEN; n++) begin
        rev = {n[0], n[1], n[2], n[3]};
        a_re[rev] = body_m[n].re;
        a_im[rev] = body_m[n].im;
    end
    for (int half = 1; half < FFT_LEN; half *= 2) begin
        for (int base = 0; base < FFT_LEN; base += 2 * half) begin
            for (int k = 0; k < half; k++) begin
                top  = base + k;
                bot  = top + half;
                tw   = k * (FFT_LEN / 2) / half;   // W16 exponent of this butterfly
                p_re = a_re[bot] * TWIDDLE_RE[tw] - a_im[bot] * TWIDDLE_IM[tw];
                p_im = a_re[bot] * TWIDDLE_IM[tw] + a_im[bot] * TWIDDLE_RE[tw];
                t_re = p_re >>> 14;
                t_im = p_im >>> 14;
                a_re[bot] = shortint'((a_re[top] - t_re) >>> 1);
                a_im[bot] = shortint'((a_im[top] - t_im) >>> 1);
                a_re[top] = shortint'((a_re[top] + t_re) >>> 1);
                a_im[top] = shortint'((a_im[top] + t_im) >>> 1);
            end
        end
    end
    for (int bin = SC_START; bin < SC_START + SC_NUM; bin++) begin
        b.data.re  = 16'(a_re[bin]);
        b.data.im  = 16'(a_im[bin]);
        b.user.sym = sym_idx_t'(sym);
        b.user.bin = 4'(bin);
        b.last     = (bin == SC_START + SC_NUM - 1);
        b.pbch     = (sym == 1) || (sym == 3);
        b.sss      = (sym == 2);
        exp_q.push_back(b);
    end
endtask

// one call per input sample, in stream order
task automatic model_step(input sample_t x);
    int re;
    int im;
    re = 0;
    im = 0;
    for (int i = 0; i < FFT_LEN - 1; i++) begin
        win_m[i] = win_m[i + 1];
    end
    win_m[FFT_LEN - 1] = x;
    for (int k = 0; k < FFT_LEN; k++) begin
        re = PSS_SEQ[k] ? re - win_m[k].re : re + win_m[k].re;
        im = PSS_SEQ[k] ? im - win_m[k].im : im + win_m[k].im;
    end
    if (!active_m) begin
        if ((re < 0 ? -re : re) + (im < 0 ? -im : im) >= THRESHOLD) begin
            active_m = 1'b1;
            sym_m    = 1;
            pos_m    = 0;
            peaks_m++;
        end
    end else begin
        if (pos_m >= CP_LEN) begin
            body_m[pos_m - CP_LEN] = x;
        end
        if (pos_m == CP_LEN + FFT_LEN - 1) begin
            transform_symbol(sym_m);
            pos_m = 0;
            if (sym_m == SYM_PER_SSB) begin
                active_m = 1'b0;   // search resumes with the next sample
            end
            sym_m++;
        end else begin
            pos_m++;
        end
    end
endtask

`endif

// ==== verif/tb_ssb_receiver.sv ====
`timescale 1ns/1ps

module tb_ssb_receiver import ssb_pkg::*; ();

    localparam int THRESHOLD = 16000;
    localparam int SC_START  = 4;
    localparam int SC_NUM    = 8;
    localparam int SEED      = 86316;
    localparam int N_SSB     = 3;   // SSBs in the stream that must be found

    logic      clk = 1'b0;
    logic      rst_n;
    sample_t   s_tdata;
    logic      s_tvalid;
    sample_t   m_tdata;
    bin_user_t m_tuser;
    logic      m_tvalid, m_tlast, pbch_valid, sss_valid;

    sample_t   stim_q [$];
    int        gap_q [$];
    int        cycles = 0;
    int        cycle_limit = 0;
    int        checks = 0;
    int        errors = 0;
    int        beats = 0;

    `include "ssb_model.svh"

    ssb_receiver #(.THRESHOLD(THRESHOLD), .SC_START(SC_START), .SC_NUM(SC_NUM)) u_dut (
        .clk_i(clk), .rst_n_i(rst_n), .s_tdata_i(s_tdata), .s_tvalid_i(s_tvalid),
        .m_tdata_o(m_tdata), .m_tuser_o(m_tuser), .m_tvalid_o(m_tvalid),
        .m_tlast_o(m_tlast), .pbch_valid_o(pbch_valid), .sss_valid_o(sss_valid)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    // ========================================
    // stimulus
    // ========================================
    function automatic sample_t rand_sample(input int amp);
        sample_t x;
        x.re = 16'(int'($urandom_range(2 * amp)) - amp);
        x.im = 16'(int'($urandom_range(2 * amp)) - amp);
        return x;
    endfunction

    task automatic push_sample(input sample_t x);
        stim_q.push_back(x);
        gap_q.push_back(4 + int'($urandom_range(2)));
    endtask

    task automatic add_noise(input int n);
        for (int i = 0; i < n; i++) begin
            push_sample(rand_sample(63));
        end
    endtask

    // sync symbol, then 3 data symbols each led by a copy of its tail
    task automatic add_ssb(input logic sync_in_data);
        sample_t body [FFT_LEN];
        sample_t pss [FFT_LEN];
        for (int n = 0; n < FFT_LEN; n++) begin
            pss[n]    = rand_sample(63);
            pss[n].re = pss[n].re + (PSS_SEQ[n] ? -16'sd2000 : 16'sd2000);
            push_sample(pss[n]);
        end
        for (int s = 1; s <= SYM_PER_SSB; s++) begin
            for (int n = 0; n < FFT_LEN; n++) begin
                body[n] = (sync_in_data && s == 2) ? pss[n] : rand_sample(1000);
            end
            for (int n = FFT_LEN - CP_LEN; n < FFT_LEN; n++) begin
                push_sample(body[n]);
            end
            for (int n = 0; n < FFT_LEN; n++) begin
                push_sample(body[n]);
            end
        end
    endtask

    task automatic send_sample(input sample_t x, input int gap);
        @(posedge clk);
        #1;
        s_tdata  = x;
        s_tvalid = 1'b1;
        @(posedge clk);
        #1;
        s_tvalid = 1'b0;
        repeat (gap - 2) @(posedge clk);
    endtask

    // ========================================
    // checking
    // ========================================
    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    always @(negedge clk) begin : check_outputs
        beat_t b;
        if (m_tvalid) begin
            beats++;
            assert (exp_q.size() > 0) else begin
                errors++;
                $display("output beat arrived while no bin was expected");
            end
            if (exp_q.size() > 0) begin
                b = exp_q.pop_front();
                compare_field("m_tdata_o", m_tdata, b.data);
                compare_field("m_tuser_o", 32'(m_tuser), 32'(b.user));
                compare_field("m_tlast_o", 32'(m_tlast), 32'(b.last));
                compare_field("pbch_valid_o", 32'(pbch_valid), 32'(b.pbch));
                compare_field("sss_valid_o", 32'(sss_valid), 32'(b.sss));
            end
        end else begin
            assert (m_tvalid === 1'b0 && !m_tlast && !pbch_valid && !sss_valid) else begin
                errors++;
                $display("tlast or a symbol flag is high without a valid beat");
            end
        end
    end

    initial begin : watchdog
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d beats still expected", cycles, exp_q.size());
        $display("checks %0d, errors %0d", checks, errors);
        $display("Simulation failed");
        $finish;
    end

    initial begin : run
        int stim_cycles;
        void'($urandom(SEED));
        rst_n       = 1'b0;
        s_tdata     = '0;
        s_tvalid    = 1'b0;
        stim_cycles = 0;
        add_noise(80);        // noise alone must stay below the threshold
        add_ssb(1'b0);
        add_noise(30);
        add_ssb(1'b1);        // the sync copy inside symbol 2 falls in the hold-off
        add_noise(30);
        add_ssb(1'b0);
        add_noise(40);
        foreach (gap_q[i]) begin
            stim_cycles += gap_q[i];
        end
        cycle_limit = 6 * stim_cycles + 500;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (stim_q[i]) begin
            model_step(stim_q[i]);
            send_sample(stim_q[i], gap_q[i]);
        end
        while (exp_q.size() > 0) begin
            @(posedge clk);
        end
        repeat (100) @(posedge clk);   // room for any stray beat to show
        compare_field("model peak count", 32'(peaks_m), 32'(N_SSB));
        compare_field("m_tvalid_o beat count", 32'(beats), 32'(3 * SC_NUM * N_SSB));
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
